/* include/issue_cfg.svh */
`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

// lanes and fetch slots per cycle
`define ISSUE_WIDTH 2

// logical registers, and physical ones behind them
`define NUM_ARCH_REGS 32
`define NUM_PHY_REGS 40

// first fetch address after reset
`define RESET_PC 32'h0000_3000

`endif

/* design/isa_pkg.sv */
`include "issue_cfg.svh"

package isa_pkg;

    typedef logic [31:0] instr_word_t;
    typedef logic [$clog2(`NUM_ARCH_REGS)-1:0] arch_reg_t;

    // primary opcode, bits 31:26
    typedef enum logic [5:0] {
        SPECIAL = 6'h00,
        J       = 6'h02,
        JAL     = 6'h03,
        BEQ     = 6'h04,
        ORI     = 6'h0d,
        LUI     = 6'h0f,
        LW      = 6'h23,
        SW      = 6'h2b
    } opcode_e;

    // funct field of SPECIAL, bits 5:0
    typedef enum logic [5:0] {
        JR      = 6'h08,
        SYSCALL = 6'h0c,
        ADDU    = 6'h21,
        SUBU    = 6'h23
    } funct_e;

    typedef enum logic [2:0] {
        ALU_R,
        IMM,
        LOAD,
        STORE,
        BRANCH,
        JUMP,
        JUMP_LINK,
        OTHER
    } instr_class_e;

    typedef struct packed {
        instr_class_e cls;
        arch_reg_t    rs;
        logic         rs_valid;
        arch_reg_t    rt;
        logic         rt_valid;
        logic         has_dst;
        arch_reg_t    dst;
        logic [31:0]  imm;
        logic [25:0]  jidx;
    } decoded_t;

endpackage

/* design/issue_pkg.sv */
`include "issue_cfg.svh"

package issue_pkg;

    typedef logic [31:0] pc_t;
    typedef logic [$clog2(`NUM_PHY_REGS)-1:0] phy_reg_t;

    // wraps freely, lanes only compare for order within a short window
    typedef logic [7:0] issue_id_t;

    // ========================================================================
    // controller to rename unit, one per fetch slot
    // ========================================================================
    typedef struct packed {
        logic               valid;
        isa_pkg::arch_reg_t rs;
        isa_pkg::arch_reg_t rt;
        logic               has_dst;
        isa_pkg::arch_reg_t dst;
    } rename_req_t;

    typedef struct packed {
        phy_reg_t phy_rs;
        phy_reg_t phy_rt;
        phy_reg_t phy_dst;
        logic     alloc;
    } rename_res_t;

    // ========================================================================
    // packet handed to one lane
    // ========================================================================
    typedef struct packed {
        logic              valid;
        pc_t               pc;
        issue_id_t         issue_id;
        isa_pkg::decoded_t info;
        phy_reg_t          phy_rs;
        phy_reg_t          phy_rt;
        phy_reg_t          phy_dst;
        pc_t               next_pc_pred;
    } issue_packet_t;

endpackage

/* design/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
    input  isa_pkg::instr_word_t instr,
    output isa_pkg::decoded_t    info
);

    isa_pkg::opcode_e   opcode;
    isa_pkg::funct_e    funct;
    isa_pkg::arch_reg_t dst_sel;
    logic               writes;

    assign opcode = isa_pkg::opcode_e'(instr[31:26]);
    assign funct  = isa_pkg::funct_e'(instr[5:0]);

    always_comb begin
        info.cls      = isa_pkg::OTHER;
        info.rs       = instr[25:21];
        info.rt       = instr[20:16];
        info.rs_valid = 1'b0;
        info.rt_valid = 1'b0;
        info.imm      = {{16{instr[15]}}, instr[15:0]};
        info.jidx     = instr[25:0];
        writes        = 1'b0;
        dst_sel       = instr[20:16];

        case (opcode)
            isa_pkg::SPECIAL: begin
                case (funct)
                    isa_pkg::ADDU, isa_pkg::SUBU: begin
                        info.cls      = isa_pkg::ALU_R;
                        info.rs_valid = 1'b1;
                        info.rt_valid = 1'b1;
                        writes        = 1'b1;
                        dst_sel       = instr[15:11];
                    end
                    // target register only, no write back
                    isa_pkg::JR: info.rs_valid = 1'b1;
                    isa_pkg::SYSCALL: info.cls = isa_pkg::OTHER;
                    default: info.cls = isa_pkg::OTHER;
                endcase
            end
            isa_pkg::ORI: begin
                info.cls      = isa_pkg::IMM;
                info.rs_valid = 1'b1;
                writes        = 1'b1;
            end
            isa_pkg::LUI: begin
                info.cls = isa_pkg::IMM;
                writes   = 1'b1;
            end
            isa_pkg::LW: begin
                info.cls      = isa_pkg::LOAD;
                info.rs_valid = 1'b1;
                writes        = 1'b1;
            end
            isa_pkg::SW: begin
                info.cls      = isa_pkg::STORE;
                info.rs_valid = 1'b1;
                info.rt_valid = 1'b1;
            end
            isa_pkg::BEQ: begin
                info.cls      = isa_pkg::BRANCH;
                info.rs_valid = 1'b1;
                info.rt_valid = 1'b1;
            end
            isa_pkg::J: info.cls = isa_pkg::JUMP;
            isa_pkg::JAL: begin
                info.cls = isa_pkg::JUMP_LINK;
                writes   = 1'b1;
                dst_sel  = 5'd31;
            end
            default: info.cls = isa_pkg::OTHER;
        endcase

        // r0 is hardwired, a write to it needs no register
        info.has_dst = writes && (dst_sel != '0);
        info.dst     = info.has_dst ? dst_sel : '0;
    end

endmodule

/* design/rename_unit.sv */
`timescale 1ns/1ps
`include "issue_cfg.svh"

module rename_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  issue_pkg::rename_req_t   req [`ISSUE_WIDTH],
    input  logic                     quiet,
    output issue_pkg::rename_res_t   res [`ISSUE_WIDTH],
    output logic [1:0]               grant_count
);

    // committed state
    issue_pkg::phy_reg_t rat [`NUM_ARCH_REGS];
    logic [`NUM_PHY_REGS-1:0] free_map;
    logic [`NUM_PHY_REGS-1:0] pend_map;

    // state after walking the granted slots of this cycle
    issue_pkg::phy_reg_t rat_w [`NUM_ARCH_REGS];
    logic [`NUM_PHY_REGS-1:0] free_w;
    logic [`NUM_PHY_REGS-1:0] pend_w;

    logic                stop;
    logic                found;
    issue_pkg::phy_reg_t pick;
    issue_pkg::phy_reg_t old_pr;

    // ========================================================================
    // in-order walk over the slots
    // ========================================================================
    always_comb begin
        rat_w       = rat;
        free_w      = free_map;
        pend_w      = pend_map;
        grant_count = 2'd0;
        stop        = 1'b0;
        pick        = '0;
        found       = 1'b0;
        old_pr      = '0;

        for (int s = 0; s < `ISSUE_WIDTH; s++) begin
            res[s] = '0;

            // lowest free register, scanning down so the last hit wins
            found = 1'b0;
            pick  = '0;
            for (int p = `NUM_PHY_REGS - 1; p >= 0; p--) begin
                if (free_w[p]) begin
                    found = 1'b1;
                    pick  = issue_pkg::phy_reg_t'(p);
                end
            end

            // first empty slot or exhausted free list ends the packet
            if (!req[s].valid || (req[s].has_dst && !found)) begin
                stop = 1'b1;
            end

            if (!stop) begin
                // sources see mappings made by earlier slots this cycle
                res[s].phy_rs = rat_w[req[s].rs];
                res[s].phy_rt = rat_w[req[s].rt];
                if (req[s].has_dst) begin
                    old_pr = rat_w[req[s].dst];
                    // reset mappings 0..31 are never recycled
                    if (old_pr >= `NUM_ARCH_REGS) begin
                        pend_w[old_pr] = 1'b1;
                    end
                    free_w[pick]       = 1'b0;
                    rat_w[req[s].dst]  = pick;
                    res[s].phy_dst     = pick;
                    res[s].alloc       = 1'b1;
                end
                grant_count = grant_count + 2'd1;
            end
        end
    end

    // ========================================================================
    // commit, with quiescent reclaim of what was pending before this edge
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
                rat[i] <= issue_pkg::phy_reg_t'(i);
            end
            for (int p = 0; p < `NUM_PHY_REGS; p++) begin
                free_map[p] <= (p >= `NUM_ARCH_REGS);
            end
            pend_map <= '0;
        end else begin
            rat <= rat_w;
            if (quiet) begin
                // old pending goes back, this edge's parked ones stay pending
                free_map <= free_w | pend_map;
                pend_map <= pend_w & ~pend_map;
            end else begin
                free_map <= free_w;
                pend_map <= pend_w;
            end
        end
    end

endmodule

/* design/issue_controller.sv */
`timescale 1ns/1ps
`include "issue_cfg.svh"

module issue_controller (
    input  logic                     clk,
    input  logic                     rst_n,
    output issue_pkg::pc_t           imem_addr,
    input  isa_pkg::instr_word_t     imem_data    [`ISSUE_WIDTH],
    input  logic                     sic_req      [`ISSUE_WIDTH],
    input  logic                     sic_busy     [`ISSUE_WIDTH],
    output issue_pkg::issue_packet_t sic_packet   [`ISSUE_WIDTH],
    output logic                     rf_alloc_wen [`ISSUE_WIDTH],
    output issue_pkg::phy_reg_t      rf_alloc_pr  [`ISSUE_WIDTH]
);

    issue_pkg::pc_t           pc;
    issue_pkg::pc_t           pc_next;
    issue_pkg::issue_id_t     issue_id;

    isa_pkg::decoded_t        dec_info     [`ISSUE_WIDTH];
    issue_pkg::pc_t           slot_pc      [`ISSUE_WIDTH];
    issue_pkg::pc_t           slot_next_pc [`ISSUE_WIDTH];
    logic                     slot_jump    [`ISSUE_WIDTH];
    issue_pkg::rename_req_t   rn_req       [`ISSUE_WIDTH];
    issue_pkg::rename_res_t   rn_res       [`ISSUE_WIDTH];
    logic [1:0]               grant_count;

    int                       lane_slot    [`ISSUE_WIDTH];
    int                       req_count;
    logic                     lane_grant   [`ISSUE_WIDTH];
    logic                     quiet;
    logic                     cut;

    // registered lane outputs, valid kept apart from payload
    logic                     pkt_valid    [`ISSUE_WIDTH];
    issue_pkg::issue_packet_t pkt_d        [`ISSUE_WIDTH];
    issue_pkg::issue_packet_t pkt_q        [`ISSUE_WIDTH];

    assign imem_addr = pc;

    for (genvar g = 0; g < `ISSUE_WIDTH; g++) begin : g_slot
        instr_decoder instr_decoder_inst (
            .instr(imem_data[g]),
            .info (dec_info[g])
        );
    end

    rename_unit rename_unit_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (rn_req),
        .quiet      (quiet),
        .res        (rn_res),
        .grant_count(grant_count)
    );

    // ========================================================================
    // lane to slot mapping and jump cut
    // ========================================================================
    always_comb begin
        req_count = 0;
        quiet     = 1'b1;
        for (int l = 0; l < `ISSUE_WIDTH; l++) begin
            lane_slot[l] = req_count;
            if (sic_req[l]) begin
                req_count = req_count + 1;
            end
            if (sic_busy[l]) begin
                quiet = 1'b0;
            end
        end
    end

    always_comb begin
        cut = 1'b0;
        for (int s = 0; s < `ISSUE_WIDTH; s++) begin
            slot_pc[s]   = pc + issue_pkg::pc_t'(4 * s);
            slot_jump[s] = (dec_info[s].cls == isa_pkg::JUMP) ||
                           (dec_info[s].cls == isa_pkg::JUMP_LINK);
            if (slot_jump[s]) begin
                slot_next_pc[s] = {slot_pc[s][31:28], dec_info[s].jidx, 2'b00};
            end else begin
                slot_next_pc[s] = slot_pc[s] + 32'd4;
            end

            rn_req[s].valid   = (s < req_count) && !cut;
            rn_req[s].rs      = dec_info[s].rs;
            rn_req[s].rt      = dec_info[s].rt;
            rn_req[s].has_dst = dec_info[s].has_dst;
            rn_req[s].dst     = dec_info[s].dst;

            // nothing after a J or JAL goes out this cycle
            if (slot_jump[s]) begin
                cut = 1'b1;
            end
        end
    end

    // follow the last granted slot, hold on a full stall
    always_comb begin
        pc_next = pc;
        for (int s = 0; s < `ISSUE_WIDTH; s++) begin
            if (int'(grant_count) == s + 1) begin
                pc_next = slot_next_pc[s];
            end
        end
    end

    // ========================================================================
    // per-lane packet build
    // ========================================================================
    always_comb begin
        for (int l = 0; l < `ISSUE_WIDTH; l++) begin
            lane_grant[l]         = sic_req[l] && (lane_slot[l] < int'(grant_count));
            pkt_d[l].valid        = lane_grant[l];
            pkt_d[l].pc           = slot_pc[lane_slot[l]];
            pkt_d[l].issue_id     = issue_id + issue_pkg::issue_id_t'(lane_slot[l]);
            pkt_d[l].info         = dec_info[lane_slot[l]];
            pkt_d[l].phy_rs       = rn_res[lane_slot[l]].phy_rs;
            pkt_d[l].phy_rt       = rn_res[lane_slot[l]].phy_rt;
            pkt_d[l].phy_dst      = rn_res[lane_slot[l]].phy_dst;
            pkt_d[l].next_pc_pred = slot_next_pc[lane_slot[l]];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= `RESET_PC;
            issue_id <= '0;
            for (int l = 0; l < `ISSUE_WIDTH; l++) begin
                pkt_valid[l]    <= 1'b0;
                rf_alloc_wen[l] <= 1'b0;
            end
        end else begin
            pc       <= pc_next;
            issue_id <= issue_id + issue_pkg::issue_id_t'(grant_count);
            for (int l = 0; l < `ISSUE_WIDTH; l++) begin
                pkt_valid[l]    <= lane_grant[l];
                rf_alloc_wen[l] <= lane_grant[l] && rn_res[lane_slot[l]].alloc;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < `ISSUE_WIDTH; l++) begin
            pkt_q[l]       <= pkt_d[l];
            rf_alloc_pr[l] <= rn_res[lane_slot[l]].phy_dst;
        end
    end

    always_comb begin
        for (int l = 0; l < `ISSUE_WIDTH; l++) begin
            sic_packet[l]       = pkt_q[l];
            sic_packet[l].valid = pkt_valid[l];
        end
    end

endmodule

/* testbench/issue_controller_sva.sv */
`timescale 1ns/1ps
`include "issue_cfg.svh"

module issue_controller_sva (
    input logic                     clk,
    input logic                     rst_n,
    input issue_pkg::issue_packet_t sic_packet   [`ISSUE_WIDTH],
    input logic                     rf_alloc_wen [`ISSUE_WIDTH],
    input issue_pkg::phy_reg_t      rf_alloc_pr  [`ISSUE_WIDTH]
);

    for (genvar l = 0; l < `ISSUE_WIDTH; l++) begin : g_lane
        // strobe and packet leave the same register stage
        a_alloc_matches_packet: assert property (@(posedge clk) disable iff (!rst_n)
            rf_alloc_wen[l] |-> sic_packet[l].valid &&
                                sic_packet[l].phy_dst == rf_alloc_pr[l])
            else $error("lane %0d allocate strobe without a matching packet", l);

        // reset mappings are never handed out
        a_alloc_above_arch: assert property (@(posedge clk) disable iff (!rst_n)
            rf_alloc_wen[l] |-> rf_alloc_pr[l] >= `NUM_ARCH_REGS)
            else $error("lane %0d allocated a reserved register", l);
    end

    a_alloc_distinct: assert property (@(posedge clk) disable iff (!rst_n)
        rf_alloc_wen[0] && rf_alloc_wen[1] |-> rf_alloc_pr[0] != rf_alloc_pr[1])
        else $error("both lanes allocated the same physical register");

endmodule

bind issue_controller issue_controller_sva issue_controller_sva_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .sic_packet  (sic_packet),
    .rf_alloc_wen(rf_alloc_wen),
    .rf_alloc_pr (rf_alloc_pr)
);

/* testbench/issue_controller_tb.sv */
`timescale 1ns/1ps
`include "issue_cfg.svh"

module issue_controller_tb;

    localparam int NUM_ROWS   = 20;
    localparam int MEM_WORDS  = 64;
    localparam int CLK_PERIOD = 20;

    typedef struct packed {
        isa_pkg::instr_class_e cls;
        logic                  jump;
        logic                  has_dst;
        logic [4:0]            dst;
        logic                  rs_used;
        logic                  rt_used;
    } ref_dec_t;

    typedef struct packed {
        logic                 valid;
        logic [31:0]          pc;
        logic [7:0]           issue_id;
        logic [31:0]          next_pc;
        isa_pkg::instr_word_t word;
        ref_dec_t             dec;
        logic [5:0]           phy_rs;
        logic [5:0]           phy_rt;
        logic [5:0]           phy_dst;
    } exp_lane_t;

    typedef struct packed {
        logic [1:0] req;
        logic [1:0] busy;
        logic [1:0] issued;
    } stim_row_t;

    // columns: lane requests {1,0}, lane busy {1,0}, instructions issued
    localparam logic [5:0] STIM_ROWS [NUM_ROWS] = '{
        {2'b11, 2'b01, 2'd2}, {2'b11, 2'b01, 2'd2}, {2'b10, 2'b01, 2'd1},
        {2'b00, 2'b01, 2'd0}, {2'b11, 2'b01, 2'd2}, {2'b11, 2'b01, 2'd1},
        {2'b11, 2'b01, 2'd1}, {2'b11, 2'b01, 2'd2}, {2'b11, 2'b10, 2'd0},
        {2'b11, 2'b11, 2'd0}, {2'b00, 2'b00, 2'd0}, {2'b11, 2'b01, 2'd2},
        {2'b01, 2'b01, 2'd1}, {2'b11, 2'b00, 2'd0}, {2'b11, 2'b01, 2'd1},
        {2'b11, 2'b00, 2'd0}, {2'b11, 2'b00, 2'd2}, {2'b11, 2'b00, 2'd0},
        {2'b11, 2'b01, 2'd2}, {2'b10, 2'b00, 2'd1}
    };

    logic                     clk;
    logic                     rst_n;
    issue_pkg::pc_t           imem_addr;
    isa_pkg::instr_word_t     imem_data    [`ISSUE_WIDTH];
    logic                     sic_req      [`ISSUE_WIDTH];
    logic                     sic_busy     [`ISSUE_WIDTH];
    issue_pkg::issue_packet_t sic_packet   [`ISSUE_WIDTH];
    logic                     rf_alloc_wen [`ISSUE_WIDTH];
    issue_pkg::phy_reg_t      rf_alloc_pr  [`ISSUE_WIDTH];

    isa_pkg::instr_word_t     prog [MEM_WORDS];

    // reference rename state
    int                       ref_rat [`NUM_ARCH_REGS];
    logic [`NUM_PHY_REGS-1:0] ref_free;
    logic [`NUM_PHY_REGS-1:0] ref_pend;
    logic [31:0]              ref_pc;
    logic [7:0]               ref_id;
    exp_lane_t                exp_q [`ISSUE_WIDTH];
    int                       exp_issued;
    int                       error_count;

    issue_controller issue_controller_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .sic_req     (sic_req),
        .sic_busy    (sic_busy),
        .sic_packet  (sic_packet),
        .rf_alloc_wen(rf_alloc_wen),
        .rf_alloc_pr (rf_alloc_pr)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ========================================================================
    // instruction memory
    // ========================================================================
    function automatic isa_pkg::instr_word_t r_type_word(int rs, int rt, int rd,
                                                         logic [5:0] funct);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, funct};
    endfunction

    function automatic isa_pkg::instr_word_t i_type_word(logic [5:0] op, int rs, int rt,
                                                         int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic isa_pkg::instr_word_t j_type_word(logic [5:0] op, logic [31:0] target);
        return {op, target[27:2]};
    endfunction

    // SYSCALL with junk fields, never writes a register
    function automatic isa_pkg::instr_word_t fill_word(logic [31:0] addr);
        return {6'h00, addr[21:2] ^ addr[31:12], 6'h0c};
    endfunction

    function automatic isa_pkg::instr_word_t fetch(logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - `RESET_PC) >> 2;
        if (idx < MEM_WORDS) begin
            return prog[idx];
        end
        return fill_word(addr);
    endfunction

    always_comb begin
        for (int g = 0; g < `ISSUE_WIDTH; g++) begin
            imem_data[g] = fetch(imem_addr + 32'(4 * g));
        end
    end

    task automatic load_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog[i] = fill_word(`RESET_PC + 32'(4 * i));
        end
        prog[0]  = i_type_word(6'h0d, 0, 1, 1);
        prog[1]  = r_type_word(1, 1, 2, 6'h21);
        // write to r0, no register
        prog[2]  = i_type_word(6'h0d, 0, 0, 5);
        prog[3]  = r_type_word(2, 1, 3, 6'h21);
        prog[4]  = i_type_word(6'h0d, 3, 4, 2);
        prog[5]  = i_type_word(6'h2b, 2, 4, 0);
        prog[6]  = i_type_word(6'h0d, 4, 5, 3);
        prog[7]  = j_type_word(6'h02, 32'h0000_3028);
        prog[8]  = i_type_word(6'h0d, 5, 6, 4);
        prog[10] = j_type_word(6'h03, 32'h0000_3038);
        prog[11] = i_type_word(6'h0d, 6, 7, 5);
        prog[14] = r_type_word(2, 3, 1, 6'h21);
        prog[15] = r_type_word(1, 1, 2, 6'h21);
        prog[16] = i_type_word(6'h0d, 1, 8, 3);
        prog[17] = i_type_word(6'h2b, 2, 8, 4);
        prog[18] = r_type_word(8, 2, 1, 6'h21);
        prog[19] = i_type_word(6'h0d, 1, 3, 7);
        prog[20] = i_type_word(6'h0d, 3, 4, 8);
        prog[21] = i_type_word(6'h2b, 3, 4, 8);
        prog[22] = r_type_word(4, 3, 5, 6'h23);
    endtask

    // ========================================================================
    // reference model
    // ========================================================================
    function automatic ref_dec_t decode_expected(isa_pkg::instr_word_t w);
        ref_dec_t   d;
        logic [4:0] dst;
        logic       writes;
        d      = '0;
        d.cls  = isa_pkg::OTHER;
        writes = 1'b0;
        dst    = w[20:16];
        case (w[31:26])
            6'h00: begin
                if (w[5:0] == 6'h21 || w[5:0] == 6'h23) begin
                    d.cls     = isa_pkg::ALU_R;
                    writes    = 1'b1;
                    dst       = w[15:11];
                    d.rs_used = 1'b1;
                    d.rt_used = 1'b1;
                end else if (w[5:0] == 6'h08) begin
                    d.rs_used = 1'b1;
                end
            end
            6'h0d: begin
                d.cls     = isa_pkg::IMM;
                writes    = 1'b1;
                d.rs_used = 1'b1;
            end
            6'h23: begin
                d.cls     = isa_pkg::LOAD;
                writes    = 1'b1;
                d.rs_used = 1'b1;
            end
            6'h0f: begin
                d.cls  = isa_pkg::IMM;
                writes = 1'b1;
            end
            6'h2b: begin
                d.cls     = isa_pkg::STORE;
                d.rs_used = 1'b1;
                d.rt_used = 1'b1;
            end
            6'h04: begin
                d.cls     = isa_pkg::BRANCH;
                d.rs_used = 1'b1;
                d.rt_used = 1'b1;
            end
            6'h02: begin
                d.cls  = isa_pkg::JUMP;
                d.jump = 1'b1;
            end
            6'h03: begin
                d.cls  = isa_pkg::JUMP_LINK;
                d.jump = 1'b1;
                writes = 1'b1;
                dst    = 5'd31;
            end
            default: d.jump = 1'b0;
        endcase
        d.has_dst = writes && (dst != 5'd0);
        d.dst     = d.has_dst ? dst : 5'd0;
        return d;
    endfunction

    task automatic advance_model(input stim_row_t row);
        int                       slot_of [`ISSUE_WIDTH];
        int                       prs     [`ISSUE_WIDTH];
        int                       prt     [`ISSUE_WIDTH];
        int                       pdst    [`ISSUE_WIDTH];
        ref_dec_t                 dec     [`ISSUE_WIDTH];
        logic [31:0]              spc     [`ISSUE_WIDTH];
        logic [31:0]              snext   [`ISSUE_WIDTH];
        logic [`NUM_PHY_REGS-1:0] parked;
        isa_pkg::instr_word_t     w;
        int                       nreq;
        int                       granted;
        int                       pick;
        int                       s;
        bit                       stop;
        nreq    = 0;
        granted = 0;
        stop    = 1'b0;
        parked  = '0;
        for (int l = 0; l < `ISSUE_WIDTH; l++) begin
            slot_of[l] = nreq;
            if (row.req[l]) begin
                nreq++;
            end
        end
        for (int k = 0; k < `ISSUE_WIDTH; k++) begin
            spc[k]   = ref_pc + 32'(4 * k);
            w        = fetch(spc[k]);
            dec[k]   = decode_expected(w);
            snext[k] = dec[k].jump ? {spc[k][31:28], w[25:0], 2'b00} : spc[k] + 32'd4;
            pick     = -1;
            for (int p = 0; p < `NUM_PHY_REGS; p++) begin
                if (ref_free[p] && pick < 0) begin
                    pick = p;
                end
            end
            if (k >= nreq || (k > 0 && dec[k-1].jump) || (dec[k].has_dst && pick < 0)) begin
                stop = 1'b1;
            end
            prs[k]  = ref_rat[w[25:21]];
            prt[k]  = ref_rat[w[20:16]];
            pdst[k] = 0;
            if (!stop) begin
                if (dec[k].has_dst) begin
                    // only recycled registers park, reset mappings stay put
                    if (ref_rat[dec[k].dst] >= `NUM_ARCH_REGS) begin
                        parked[ref_rat[dec[k].dst]] = 1'b1;
                    end
                    ref_free[pick]       = 1'b0;
                    ref_rat[dec[k].dst]  = pick;
                    pdst[k]              = pick;
                end
                granted++;
            end
        end
        for (int l = 0; l < `ISSUE_WIDTH; l++) begin
            s                 = slot_of[l];
            exp_q[l].valid    = row.req[l] && (s < granted);
            exp_q[l].pc       = spc[s];
            exp_q[l].issue_id = ref_id + 8'(s);
            exp_q[l].next_pc  = snext[s];
            exp_q[l].word     = fetch(spc[s]);
            exp_q[l].dec      = dec[s];
            exp_q[l].phy_rs   = 6'(prs[s]);
            exp_q[l].phy_rt   = 6'(prt[s]);
            exp_q[l].phy_dst  = 6'(pdst[s]);
        end
        // quiescent reclaim, this edge's parked registers wait for the next one
        if (row.busy == 2'b00) begin
            ref_free = ref_free | ref_pend;
            ref_pend = parked;
        end else begin
            ref_pend = ref_pend | parked;
        end
        if (granted > 0) begin
            ref_pc = snext[granted-1];
        end
        ref_id = ref_id + 8'(granted);
    endtask

    // ========================================================================
    // checks
    // ========================================================================
    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string what);
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch at %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("Some tests failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic compare_lanes();
        int n;
        n = 0;
        for (int l = 0; l < `ISSUE_WIDTH; l++) begin
            if (sic_packet[l].valid) begin
                n++;
            end
            check(sic_packet[l].valid, exp_q[l].valid, $sformatf("lane %0d valid", l));
            check(rf_alloc_wen[l], exp_q[l].valid && exp_q[l].dec.has_dst,
                  $sformatf("lane %0d alloc strobe", l));
            if (exp_q[l].valid) begin
                check(sic_packet[l].pc, exp_q[l].pc, $sformatf("lane %0d pc", l));
                check(sic_packet[l].issue_id, exp_q[l].issue_id,
                      $sformatf("lane %0d issue id", l));
                check(sic_packet[l].next_pc_pred, exp_q[l].next_pc,
                      $sformatf("lane %0d next pc", l));
                check(sic_packet[l].info.cls, exp_q[l].dec.cls,
                      $sformatf("lane %0d class", l));
                check(sic_packet[l].info.rs, exp_q[l].word[25:21],
                      $sformatf("lane %0d rs", l));
                check(sic_packet[l].info.rt, exp_q[l].word[20:16],
                      $sformatf("lane %0d rt", l));
                check(sic_packet[l].info.rs_valid, exp_q[l].dec.rs_used,
                      $sformatf("lane %0d rs_valid", l));
                check(sic_packet[l].info.rt_valid, exp_q[l].dec.rt_used,
                      $sformatf("lane %0d rt_valid", l));
                check(sic_packet[l].info.imm,
                      {{16{exp_q[l].word[15]}}, exp_q[l].word[15:0]},
                      $sformatf("lane %0d imm", l));
                check(sic_packet[l].info.jidx, exp_q[l].word[25:0],
                      $sformatf("lane %0d jump index", l));
                check(sic_packet[l].info.has_dst, exp_q[l].dec.has_dst,
                      $sformatf("lane %0d has_dst", l));
                check(sic_packet[l].info.dst, exp_q[l].dec.dst, $sformatf("lane %0d dst", l));
                if (exp_q[l].dec.rs_used) begin
                    check(sic_packet[l].phy_rs, exp_q[l].phy_rs,
                          $sformatf("lane %0d phy_rs", l));
                end
                if (exp_q[l].dec.rt_used) begin
                    check(sic_packet[l].phy_rt, exp_q[l].phy_rt,
                          $sformatf("lane %0d phy_rt", l));
                end
                if (exp_q[l].dec.has_dst) begin
                    check(sic_packet[l].phy_dst, exp_q[l].phy_dst,
                          $sformatf("lane %0d phy_dst", l));
                    check(rf_alloc_pr[l], exp_q[l].phy_dst,
                          $sformatf("lane %0d alloc register", l));
                end
            end
        end
        check(n, exp_issued, "issued count");
    endtask

    // ========================================================================
    // main sequence
    // ========================================================================
    initial begin
        error_count = 0;
        exp_issued  = 0;
        rst_n       = 1'b0;
        for (int l = 0; l < `ISSUE_WIDTH; l++) begin
            sic_req[l]  = 1'b0;
            sic_busy[l] = 1'b0;
            exp_q[l]    = '0;
        end
        load_program();
        for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
            ref_rat[i] = i;
        end
        for (int p = 0; p < `NUM_PHY_REGS; p++) begin
            ref_free[p] = (p >= `NUM_ARCH_REGS);
        end
        ref_pend = '0;
        ref_pc   = `RESET_PC;
        ref_id   = '0;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        compare_lanes();
        check(imem_addr, `RESET_PC, "imem_addr after reset");

        for (int r = 0; r < NUM_ROWS; r++) begin
            @(posedge clk);
            for (int l = 0; l < `ISSUE_WIDTH; l++) begin
                sic_req[l]  <= STIM_ROWS[r][4 + l];
                sic_busy[l] <= STIM_ROWS[r][2 + l];
            end
            @(negedge clk);
            // outputs now hold the previous row's decisions
            compare_lanes();
            check(imem_addr, ref_pc, "imem_addr");
            advance_model(stim_row_t'(STIM_ROWS[r]));
            exp_issued = int'(STIM_ROWS[r][1:0]);
        end

        @(posedge clk);
        for (int l = 0; l < `ISSUE_WIDTH; l++) begin
            sic_req[l]  <= 1'b0;
            sic_busy[l] <= 1'b0;
        end
        @(negedge clk);
        compare_lanes();
        check(imem_addr, ref_pc, "final imem_addr");

        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((NUM_ROWS + 20) * CLK_PERIOD);
        $display("Timeout: the stimulus table did not finish in time");
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule

/* build.f */
+incdir+include
design/isa_pkg.sv
design/issue_pkg.sv
design/instr_decoder.sv
design/rename_unit.sv
design/issue_controller.sv
testbench/issue_controller_sva.sv
testbench/issue_controller_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the issue stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module issue_controller_tb -o issue_controller_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/issue_controller_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^All tests passed$"; then
    exit 0
fi
exit 1
